/* filelist.f */
hdl/spuAdsrPkg.sv
hdl/spuAdsrDecode.sv
hdl/spuAdsrRate.sv
hdl/spuAdsrUpdate.sv
hdl/spuVoiceEnvelope.sv
hdl/spuAdsrTop.sv
test/spuAdsr_asserts.sv
test/tbSpuAdsr.sv

/* hdl/spuAdsrDecode.sv */
`default_nettype none

module spuAdsrDecode (
	input  spuAdsrPkg::voiceState_t	i_curState,
	output spuAdsrPkg::envParam_t	o_param
);
	import spuAdsrPkg::*;

	logic [15:0] lo;
	logic [15:0] hi;

	assign lo = i_curState.adsrLo;
	assign hi = i_curState.adsrHi;

	always_comb
	begin
		// Safe defaults, every phase overrides them
		o_param              = '0;
		o_param.nextPhase    = i_curState.phase;
		o_param.compareLevel = 1'b0;

		case (i_curState.phase)
			AdsrAttack:
			begin
				o_param.exponential  = lo[15];
				o_param.decrease     = 1'b0;				// Always rising
				o_param.shift        = lo[14:10];
				o_param.step         = {2'b01, ~lo[9:8]};	// 7 minus rate bits
				// Leave attack only after key-on has been consumed
				o_param.nextPhase    = i_curState.keyOnPending ? AdsrAttack : AdsrDecay;
				o_param.compareLevel = 1'b1;				// Exit at max level
			end
			AdsrDecay:
			begin
				o_param.exponential  = 1'b1;				// Decay is always exp
				o_param.decrease     = 1'b1;
				o_param.shift        = {1'b0, lo[7:4]};	// 0..15 only
				o_param.step         = 4'sb1000;			// -8
				o_param.nextPhase    = AdsrSustain;
				o_param.compareLevel = 1'b1;				// Exit below sustain level
			end
			AdsrSustain:
			begin
				o_param.exponential  = hi[15];
				o_param.decrease     = hi[14];
				o_param.shift        = hi[12:8];
				// Increase gives +7..+4, decrease gives -8..-5
				o_param.step         = {hi[14], ~hi[14], hi[14] ? hi[7:6] : ~hi[7:6]};
				o_param.nextPhase    = AdsrSustain;		// Held until key-off
			end
			AdsrRelease:
			begin
				o_param.exponential  = hi[5];
				o_param.decrease     = 1'b1;
				o_param.shift        = hi[4:0];
				o_param.step         = 4'sb1000;			// -8
				o_param.nextPhase    = AdsrRelease;
			end
			default:
			begin
				o_param.nextPhase    = AdsrRelease;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/spuAdsrPkg.sv */
`default_nettype none

package spuAdsrPkg;

	// ----------------------------------------
	// Architecture constants
	// ----------------------------------------
	localparam int NumVoices = 24;
	localparam int VoiceW    = 5;			// Enough for 0..23
	localparam int LevelW    = 15;
	localparam int CountW    = 23;

	localparam logic [LevelW-1:0] MaxLevel     = 15'h7FFF;
	localparam logic [LevelW-1:0] ExpKneeLevel = 15'h6000;	// Exp attack slows above this
	localparam logic [CountW-1:0] ReloadAt     = 23'd1;		// Count value that fires an update
	localparam logic [4:0]        ShiftKnee    = 5'd11;		// Shift split point, period vs step

	// Envelope phase, encoding matches the hardware state field
	typedef enum logic [1:0] {
		AdsrAttack  = 2'd0,
		AdsrDecay   = 2'd1,
		AdsrSustain = 2'd2,
		AdsrRelease = 2'd3
	} adsrPhase_e;

	// ----------------------------------------
	// Per-voice storage and datapath bundles
	// ----------------------------------------
	typedef struct packed {
		logic [LevelW-1:0] level;
		adsrPhase_e        phase;
		logic [CountW-1:0] cycleCount;
		logic              keyOnPending;
		logic [15:0]       adsrLo;		// Attack, decay, sustain level
		logic [15:0]       adsrHi;		// Sustain rate, release
	} voiceState_t;

	typedef struct packed {
		logic              exponential;
		logic              decrease;
		logic [4:0]        shift;
		logic signed [3:0] step;			// +7..+4 or -8..-5
		adsrPhase_e        nextPhase;
		logic              compareLevel;	// Phase exit depends on level
	} envParam_t;

	typedef struct packed {
		logic [LevelW-1:0] level;
		adsrPhase_e        phase;
		logic [CountW-1:0] cycleCount;
		logic              updateLevel;
		logic              updatePhase;
		logic              clearKeyOn;
	} envResult_t;

	typedef struct packed {
		logic [VoiceW-1:0] voice;
		logic [LevelW-1:0] level;
		adsrPhase_e        phase;
	} envReport_t;

endpackage

`default_nettype wire

/* hdl/spuAdsrRate.sv */
`default_nettype none

module spuAdsrRate (
	input  spuAdsrPkg::envParam_t					i_param,
	input  logic [spuAdsrPkg::LevelW-1:0]			i_level,
	output logic [spuAdsrPkg::CountW-1:0]			o_period,
	output logic signed [spuAdsrPkg::LevelW-1:0]	o_step
);
	import spuAdsrPkg::*;

	logic [4:0]               periodShift;
	logic [4:0]               stepShift;
	logic [CountW-1:0]        basePeriod;
	logic signed [LevelW-1:0] baseStep;
	logic signed [30:0]       scaledStep;		// step * level, full width
	logic                     slowAttack;
	logic                     expDecrease;

	// ----------------------------------------
	// Split shift into period and step parts
	// ----------------------------------------
	always_comb
	begin
		periodShift = (i_param.shift > ShiftKnee) ? i_param.shift - ShiftKnee : 5'd0;
		stepShift   = (i_param.shift < ShiftKnee) ? ShiftKnee - i_param.shift : 5'd0;
	end

	assign basePeriod = CountW'(1) << periodShift;	// Up to 1 << 20
	// Sign extended 4-bit step, then scaled by 2^stepShift
	assign baseStep   = $signed({{(LevelW-4){i_param.step[3]}}, i_param.step}) <<< stepShift;

	assign slowAttack  = i_param.exponential & ~i_param.decrease & (i_level > ExpKneeLevel);
	assign expDecrease = i_param.exponential & i_param.decrease;

	// Level is unsigned, zero extend before the signed multiply
	assign scaledStep = baseStep * $signed({1'b0, i_level});

	always_comb
	begin
		// Exp attack above knee runs four times slower
		o_period = slowAttack ? (basePeriod << 2) : basePeriod;

		if (expDecrease)
		begin
			o_step = scaledStep[29:15];	// Divide by 32768, floor
		end
		else
		begin
			o_step = baseStep;
		end
	end

endmodule

`default_nettype wire

/* hdl/spuAdsrTop.sv */
`default_nettype none

module spuAdsrTop (
	input  logic								i_clk,
	input  logic								i_reset,
	input  logic								i_spuEnable,
	input  logic								i_sampleStrobe,
	input  logic								i_keyOn,
	input  logic								i_keyOff,
	input  logic [spuAdsrPkg::VoiceW-1:0]		i_keyVoice,
	input  logic								i_regWrite,
	input  logic [spuAdsrPkg::VoiceW-1:0]		i_regVoice,
	input  logic								i_regHigh,
	input  logic [15:0]						i_regData,
	output logic								o_busy,
	output logic								o_reportValid,
	output spuAdsrPkg::envReport_t			o_report
);
	import spuAdsrPkg::*;

	logic                     updateEnable;
	voiceState_t              curState;		// Gated level, current voice
	envParam_t                param;
	envResult_t               result;
	logic [CountW-1:0]        period;
	logic signed [LevelW-1:0] step;

	// Sequencer and state storage
	spuVoiceEnvelope u_spuVoiceEnvelope (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_spuEnable    (i_spuEnable),
		.i_sampleStrobe (i_sampleStrobe),
		.i_keyOn        (i_keyOn),
		.i_keyOff       (i_keyOff),
		.i_keyVoice     (i_keyVoice),
		.i_regWrite     (i_regWrite),
		.i_regVoice     (i_regVoice),
		.i_regHigh      (i_regHigh),
		.i_regData      (i_regData),
		.i_result       (result),
		.o_updateEnable (updateEnable),
		.o_curState     (curState),
		.o_busy         (o_busy),
		.o_reportValid  (o_reportValid),
		.o_report       (o_report)
	);

	spuAdsrDecode u_spuAdsrDecode (
		.i_curState (curState),
		.o_param    (param)
	);

	spuAdsrRate u_spuAdsrRate (
		.i_param  (param),
		.i_level  (curState.level),
		.o_period (period),
		.o_step   (step)
	);

	spuAdsrUpdate u_spuAdsrUpdate (
		.i_updateEnable (updateEnable),
		.i_curState     (curState),
		.i_param        (param),
		.i_period       (period),
		.i_step         (step),
		.o_result       (result)
	);

endmodule

`default_nettype wire

/* hdl/spuAdsrUpdate.sv */
`default_nettype none

module spuAdsrUpdate (
	input  logic									i_updateEnable,
	input  spuAdsrPkg::voiceState_t				i_curState,
	input  spuAdsrPkg::envParam_t					i_param,
	input  logic [spuAdsrPkg::CountW-1:0]			i_period,
	input  logic signed [spuAdsrPkg::LevelW-1:0]	i_step,
	output spuAdsrPkg::envResult_t				o_result
);
	import spuAdsrPkg::*;

	logic              reachCount;
	logic              levelUpdate;
	logic              tooBig;
	logic              tooLow;
	logic [15:0]       susLevel;
	logic [4:0]        susMul;
	logic signed [16:0] levelSum;
	logic [LevelW-1:0] clampedLevel;

	// Sustain level is (lo[3:0] + 1) * 2048, needs 16 bits for 0x8000
	assign susMul   = {1'b0, i_curState.adsrLo[3:0]} + 5'd1;
	assign susLevel = {susMul, 11'd0};

	// ----------------------------------------
	// Counter and level step
	// ----------------------------------------
	assign reachCount  = (i_curState.cycleCount == ReloadAt);
	assign levelUpdate = i_updateEnable & reachCount;

	assign levelSum = $signed({2'b00, i_curState.level})
	                + $signed({{2{i_step[LevelW-1]}}, i_step});

	always_comb
	begin
		if (levelSum[16])					// Went negative
		begin
			clampedLevel = '0;
		end
		else if (levelSum[15])			// Past 0x7FFF
		begin
			clampedLevel = MaxLevel;
		end
		else
		begin
			clampedLevel = levelSum[LevelW-1:0];
		end
	end

	// Phase exit tests use the level before this step
	assign tooBig = (i_curState.level == MaxLevel) && (i_curState.phase == AdsrAttack);
	assign tooLow = ({1'b0, i_curState.level} < susLevel) && (i_curState.phase == AdsrDecay);

	always_comb
	begin
		o_result             = '0;
		o_result.level       = clampedLevel;
		o_result.phase       = i_param.nextPhase;
		// Reload on expiry, otherwise keep counting down
		o_result.cycleCount  = reachCount ? i_period : i_curState.cycleCount - CountW'(1);
		o_result.updateLevel = levelUpdate;
		// Level-gated phases move only on threshold, others just restate
		o_result.updatePhase = levelUpdate & (i_param.compareLevel ? (tooBig | tooLow) : 1'b1);
		o_result.clearKeyOn  = levelUpdate & i_curState.keyOnPending;
	end

endmodule

`default_nettype wire

/* hdl/spuVoiceEnvelope.sv */
`default_nettype none

module spuVoiceEnvelope (
	input  logic								i_clk,
	input  logic								i_reset,
	input  logic								i_spuEnable,
	input  logic								i_sampleStrobe,
	input  logic								i_keyOn,
	input  logic								i_keyOff,
	input  logic [spuAdsrPkg::VoiceW-1:0]		i_keyVoice,
	input  logic								i_regWrite,
	input  logic [spuAdsrPkg::VoiceW-1:0]		i_regVoice,
	input  logic								i_regHigh,
	input  logic [15:0]						i_regData,
	input  spuAdsrPkg::envResult_t			i_result,
	output logic								o_updateEnable,
	output spuAdsrPkg::voiceState_t			o_curState,
	output logic								o_busy,
	output logic								o_reportValid,
	output spuAdsrPkg::envReport_t			o_report
);
	import spuAdsrPkg::*;

	voiceState_t       voiceMem [NumVoices];
	logic [VoiceW-1:0] sweepIdx;		// Voice read this cycle
	logic              sweepActive;
	envReport_t        reportNext;

	// ----------------------------------------
	// Sweep sequencer
	// ----------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			sweepActive <= 1'b0;
			sweepIdx    <= '0;
		end
		else if (sweepActive)
		begin
			if (sweepIdx == VoiceW'(NumVoices - 1))	// Last voice
			begin
				sweepActive <= 1'b0;
				sweepIdx    <= '0;
			end
			else
			begin
				sweepIdx <= sweepIdx + VoiceW'(1);
			end
		end
		else if (i_sampleStrobe)			// Strobe mid-sweep is dropped
		begin
			sweepActive <= 1'b1;
			sweepIdx    <= '0;
		end
	end

	assign o_updateEnable = sweepActive;
	assign o_busy         = sweepActive;

	// Selected voice, level forced to zero while the SPU is off
	always_comb
	begin
		o_curState = voiceMem[sweepIdx];
		if (!i_spuEnable)
		begin
			o_curState.level = '0;
		end
	end

	// ----------------------------------------
	// Voice storage, writeback then commands
	// ----------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int v = 0; v < NumVoices; v++)
			begin
				voiceMem[v].level        <= '0;
				voiceMem[v].phase        <= AdsrRelease;	// Silent voice
				voiceMem[v].cycleCount   <= ReloadAt;
				voiceMem[v].keyOnPending <= 1'b0;
				voiceMem[v].adsrLo       <= '0;
				voiceMem[v].adsrHi       <= '0;
			end
		end
		else
		begin
			if (sweepActive)
			begin
				voiceMem[sweepIdx].cycleCount <= i_result.cycleCount;
				if (i_result.updateLevel)
					voiceMem[sweepIdx].level <= i_result.level;
				if (i_result.updatePhase)
					voiceMem[sweepIdx].phase <= i_result.phase;
				if (i_result.clearKeyOn)
					voiceMem[sweepIdx].keyOnPending <= 1'b0;
			end

			if (i_regWrite)
			begin
				if (i_regHigh)
					voiceMem[i_regVoice].adsrHi <= i_regData;
				else
					voiceMem[i_regVoice].adsrLo <= i_regData;
			end

			// Commands come last so they override the writeback
			if (i_keyOn)
			begin
				voiceMem[i_keyVoice].level        <= '0;
				voiceMem[i_keyVoice].phase        <= AdsrAttack;
				voiceMem[i_keyVoice].cycleCount   <= ReloadAt;	// Update on next visit
				voiceMem[i_keyVoice].keyOnPending <= 1'b1;
			end
			if (i_keyOff)
			begin
				voiceMem[i_keyVoice].phase      <= AdsrRelease;
				voiceMem[i_keyVoice].cycleCount <= ReloadAt;
			end
		end
	end

	// ----------------------------------------
	// Report register
	// ----------------------------------------
	always_comb
	begin
		reportNext.voice = sweepIdx;
		reportNext.level = i_result.updateLevel ? i_result.level : o_curState.level;
		reportNext.phase = i_result.updatePhase ? i_result.phase : o_curState.phase;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_reportValid <= 1'b0;
		else
			o_reportValid <= sweepActive;	// One cycle behind the read
	end

	always_ff @(posedge i_clk)
	begin
		o_report <= reportNext;			// Payload only, no reset
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbSpuAdsr \
	-f filelist.f \
	&& ./obj_dir/VtbSpuAdsr | tee /dev/stderr | grep -q "^No errors$" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* test/spuAdsr_asserts.sv */
`default_nettype none

module spuAdsr_asserts (
	input logic						i_clk,
	input logic						i_reset,
	input logic						i_reportValid,
	input spuAdsrPkg::envResult_t		i_result,
	input spuAdsrPkg::voiceState_t	i_curState
);
	timeunit 1ns;
	timeprecision 1ps;
	import spuAdsrPkg::*;

	int   validRun;		// Consecutive cycles with a report
	logic rising;		// Phase adds a positive step

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			validRun <= 0;
		else if (i_reportValid)
			validRun <= validRun + 1;
		else
			validRun <= 0;
	end

	assign rising = (i_curState.phase == AdsrAttack)
		|| ((i_curState.phase == AdsrSustain) && !i_curState.adsrHi[14]);

	// ----------------------------------------
	// Report flag and level range
	// ----------------------------------------
	assert property (@(posedge i_clk) i_reset |=> !i_reportValid)
		else $error("report valid set while in reset");

	// One sweep is 24 voices, never longer
	assert property (@(posedge i_clk) disable iff (i_reset) validRun <= NumVoices)
		else $error("more than 24 reports in a row");

	// Clamp at the top, a rising step never wraps below the old level
	assert property (@(posedge i_clk) disable iff (i_reset)
		(i_result.updateLevel && rising) |-> (i_result.level >= i_curState.level))
		else $error("rising level wrapped past maximum");

endmodule

bind spuVoiceEnvelope spuAdsr_asserts u_spuAdsrAsserts (
	.i_clk         (i_clk),
	.i_reset       (i_reset),
	.i_reportValid (o_reportValid),
	.i_result      (i_result),
	.i_curState    (o_curState)
);

`default_nettype wire

/* test/tbSpuAdsr.sv */
`default_nettype none

module tbSpuAdsr;
	timeunit 1ns;
	timeprecision 1ps;
	import spuAdsrPkg::*;

	logic              clk;
	logic              reset;
	logic              spuEnable;
	logic              sampleStrobe;
	logic              keyOn;
	logic              keyOff;
	logic [VoiceW-1:0] keyVoice;
	logic              regWrite;
	logic [VoiceW-1:0] regVoice;
	logic              regHigh;
	logic [15:0]       regData;
	logic              busy;
	logic              reportValid;
	envReport_t        report;

	voiceState_t mState [NumVoices];	// Reference model, one entry per voice
	envReport_t  lastRep [NumVoices];	// Last DUT report per voice
	envReport_t  expQ [$];
	logic        modelEnable;
	int          errors;
	int          seed;

	spuAdsrTop u_spuAdsrTop (
		.i_clk          (clk),
		.i_reset        (reset),
		.i_spuEnable    (spuEnable),
		.i_sampleStrobe (sampleStrobe),
		.i_keyOn        (keyOn),
		.i_keyOff       (keyOff),
		.i_keyVoice     (keyVoice),
		.i_regWrite     (regWrite),
		.i_regVoice     (regVoice),
		.i_regHigh      (regHigh),
		.i_regData      (regData),
		.o_busy         (busy),
		.o_reportValid  (reportValid),
		.o_report       (report)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;		// 40 ns period
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkLevel(input string name, input logic [LevelW-1:0] expVal,
		input logic [LevelW-1:0] actVal);
		if (actVal !== expVal)
		begin
			$display("Error %s: level expected %0d, got %0d", name, expVal, actVal);
			errors++;
		end
	endtask

	task automatic checkPhase(input string name, input adsrPhase_e expVal, input adsrPhase_e actVal);
		if (actVal !== expVal)
		begin
			$display("Error %s: phase expected %s, got %s", name, expVal.name(), actVal.name());
			errors++;
		end
	endtask

	task automatic checkVoice(input string name, input logic [VoiceW-1:0] expVal,
		input logic [VoiceW-1:0] actVal);
		if (actVal !== expVal)
		begin
			$display("Error %s: voice expected %0d, got %0d", name, expVal, actVal);
			errors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			$display("Error %s: flag expected %b, got %b", name, expVal, actVal);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	task automatic modelKey(input int v, input logic on);
		mState[v].cycleCount = ReloadAt;
		if (on)
		begin
			mState[v].level        = '0;
			mState[v].phase        = AdsrAttack;
			mState[v].keyOnPending = 1'b1;
		end
		else
			mState[v].phase = AdsrRelease;
	endtask

	task automatic modelVoice(input int v);
		voiceState_t s;
		envReport_t  r;
		int          lvl;
		int          stp;
		int          shft;
		int          per;
		int          sum;
		int          susLvl;
		logic        expo;
		logic        decr;
		logic        cmpLvl;
		logic        lvlUpd;
		logic        phUpd;
		adsrPhase_e  nxt;
		s      = mState[v];
		lvl    = modelEnable ? int'(s.level) : 0;	// SPU off reads as silent
		susLvl = (int'(s.adsrLo[3:0]) + 1) * 2048;
		cmpLvl = 1'b1;
		decr   = 1'b1;
		stp    = -8;
		case (s.phase)
			AdsrAttack:
			begin
				expo = s.adsrLo[15];
				decr = 1'b0;
				shft = int'(s.adsrLo[14:10]);
				stp  = 7 - int'(s.adsrLo[9:8]);
				nxt  = s.keyOnPending ? AdsrAttack : AdsrDecay;
			end
			AdsrDecay:
			begin
				expo = 1'b1;
				shft = int'(s.adsrLo[7:4]);
				nxt  = AdsrSustain;
			end
			AdsrSustain:
			begin
				expo   = s.adsrHi[15];
				decr   = s.adsrHi[14];
				shft   = int'(s.adsrHi[12:8]);
				stp    = decr ? int'(s.adsrHi[7:6]) - 8 : 7 - int'(s.adsrHi[7:6]);
				nxt    = AdsrSustain;
				cmpLvl = 1'b0;
			end
			default:
			begin
				expo   = s.adsrHi[5];
				shft   = int'(s.adsrHi[4:0]);
				nxt    = AdsrRelease;
				cmpLvl = 1'b0;
			end
		endcase
		// Shift above 11 stretches the period, below 11 grows the step
		per = 1 << ((shft > 11) ? shft - 11 : 0);
		stp = stp * (1 << ((shft < 11) ? 11 - shft : 0));
		if (expo && !decr && lvl > int'(ExpKneeLevel))
			per = per * 4;
		if (expo && decr)
			stp = (stp * lvl) >>> 15;		// Floor of step * level / 32768
		sum = lvl + stp;
		if (sum < 0)
			sum = 0;
		else if (sum > int'(MaxLevel))
			sum = int'(MaxLevel);
		lvlUpd = (s.cycleCount == ReloadAt);
		if (cmpLvl)
			phUpd = lvlUpd && ((s.phase == AdsrAttack && lvl == int'(MaxLevel))
				|| (s.phase == AdsrDecay && lvl < susLvl));
		else
			phUpd = lvlUpd;
		r.voice = VoiceW'(v);
		r.level = lvlUpd ? LevelW'(sum) : LevelW'(lvl);
		r.phase = phUpd ? nxt : s.phase;
		expQ.push_back(r);
		if (lvlUpd)
		begin
			mState[v].level        = LevelW'(sum);
			mState[v].cycleCount   = CountW'(per);
			mState[v].keyOnPending = 1'b0;
		end
		else
			mState[v].cycleCount = s.cycleCount - CountW'(1);
		if (phUpd)
			mState[v].phase = nxt;
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	// cmdKind 1 keys on, 2 keys off, voice cmdAt while it is swept
	task automatic runSweep(input string name, input int cmdKind, input int cmdAt);
		int got;
		int cycles;
		expQ.delete();
		for (int v = 0; v < NumVoices; v++)
		begin
			modelVoice(v);
			if (v == cmdAt && cmdKind != 0)
				modelKey(v, cmdKind == 1);	// Command lands after the writeback
		end
		@(posedge clk);
		sampleStrobe <= 1'b1;
		@(posedge clk);
		got    = 0;
		cycles = 0;
		while (got < NumVoices && cycles < 200)
		begin
			sampleStrobe <= (cycles == 10);	// Mid-sweep strobe, must be dropped
			keyOn        <= (cmdKind == 1) && (cycles == cmdAt);
			keyOff       <= (cmdKind == 2) && (cycles == cmdAt);
			keyVoice     <= VoiceW'(cmdAt);
			@(negedge clk);
			// Busy while the 24 voices are read, each report one cycle later
			checkFlag(name, cycles < NumVoices, busy);
			checkFlag(name, (cycles > 0) && (cycles <= NumVoices), reportValid);
			if (reportValid)
			begin
				checkVoice(name, expQ[got].voice, report.voice);
				checkLevel(name, expQ[got].level, report.level);
				checkPhase(name, expQ[got].phase, report.phase);
				lastRep[got] = report;
				got++;
			end
			@(posedge clk);
			cycles++;
		end
		sampleStrobe <= 1'b0;
		keyOn        <= 1'b0;
		keyOff       <= 1'b0;
		if (got < NumVoices)
		begin
			$display("Timeout waiting for report in %s", name);
			errors++;
		end
	endtask

	task automatic pressKey(input int v, input logic on);
		@(posedge clk);
		keyVoice <= VoiceW'(v);
		keyOn    <= on;
		keyOff   <= !on;
		@(posedge clk);
		keyOn    <= 1'b0;
		keyOff   <= 1'b0;
		modelKey(v, on);
	endtask

	task automatic writeSetting(input int v, input logic high, input logic [15:0] data);
		@(posedge clk);
		regWrite <= 1'b1;
		regVoice <= VoiceW'(v);
		regHigh  <= high;
		regData  <= data;
		@(posedge clk);
		regWrite <= 1'b0;
		if (high)
			mState[v].adsrHi = data;
		else
			mState[v].adsrLo = data;
	endtask

	task automatic setEnable(input logic en);
		@(posedge clk);
		spuEnable   <= en;
		modelEnable = en;
	endtask

	// Short attack and decay shifts so phases finish within a few sweeps
	function automatic logic [15:0] randomLo();
		logic [15:0] w;
		w       = 16'($random(seed));
		w[14:12] = 3'b000;
		w[7:6]  = 2'b00;
		return w;
	endfunction

	function automatic logic [15:0] randomHi();
		logic [15:0] w;
		w        = 16'($random(seed));
		w[12:11] = 2'b00;		// Sustain shift 0..7
		w[4:2]   = 3'b000;		// Release shift 0..3
		return w;
	endfunction

	task automatic keyAllRandom();
		for (int v = 2; v < NumVoices; v++)
		begin
			writeSetting(v, 1'b0, randomLo());
			writeSetting(v, 1'b1, randomHi());
			pressKey(v, 1'b1);
		end
	endtask

	initial
	begin
		seed         = 32'h7a0cc2a3;
		errors       = 0;
		reset        = 1'b1;
		spuEnable    = 1'b1;
		sampleStrobe = 1'b0;
		keyOn        = 1'b0;
		keyOff       = 1'b0;
		keyVoice     = '0;
		regWrite     = 1'b0;
		regVoice     = '0;
		regHigh      = 1'b0;
		regData      = '0;
		modelEnable  = 1'b1;
		for (int v = 0; v < NumVoices; v++)
		begin
			mState[v]       = '0;
			mState[v].phase = AdsrRelease;
			mState[v].cycleCount = ReloadAt;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// Idle after reset, then one silent sweep
		@(negedge clk);
		checkFlag("reset", 1'b0, reportValid);
		checkFlag("reset", 1'b0, busy);
		runSweep("firstSweep", 0, -1);
		for (int v = 0; v < NumVoices; v++)
		begin
			checkLevel("firstSweep", '0, lastRep[v].level);
			checkPhase("firstSweep", AdsrRelease, lastRep[v].phase);
		end

		// Attack to max, decay to sustain level 16384, sustain rises and clamps
		for (int v = 0; v < 2; v++)
		begin
			writeSetting(v, 1'b0, 16'h0007);
			writeSetting(v, 1'b1, 16'h0000);
			pressKey(v, 1'b1);
		end
		keyAllRandom();
		repeat (120) runSweep("attackDecay", 0, -1);
		checkPhase("attackDecay", AdsrSustain, lastRep[0].phase);
		checkLevel("attackDecay", MaxLevel, lastRep[0].level);

		// New sustain rates, voice 1 falls linearly and clamps at zero
		writeSetting(1, 1'b1, 16'h4000);
		for (int v = 2; v < NumVoices; v++)
			writeSetting(v, 1'b1, randomHi());
		repeat (60) runSweep("sustain", 0, -1);
		checkLevel("sustain", '0, lastRep[1].level);
		checkPhase("sustain", AdsrSustain, lastRep[1].phase);

		for (int v = 0; v < NumVoices; v++)
			pressKey(v, 1'b0);
		repeat (250) runSweep("release", 0, -1);
		for (int v = 0; v < NumVoices; v++)
		begin
			checkLevel("release", '0, lastRep[v].level);
			checkPhase("release", AdsrRelease, lastRep[v].phase);
		end

		// SPU off, then commands on the voice being swept
		keyAllRandom();
		repeat (20) runSweep("enabled", 0, -1);
		setEnable(1'b0);
		repeat (6) runSweep("disabled", 0, -1);
		setEnable(1'b1);
		repeat (4) runSweep("reenabled", 0, -1);
		runSweep("keyOnHit", 1, 5);
		runSweep("keyOffHit", 2, 9);
		runSweep("afterHit", 0, -1);
		checkPhase("afterHit", AdsrAttack, lastRep[5].phase);
		checkPhase("afterHit", AdsrRelease, lastRep[9].phase);

		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
